// ==== src/aes_pkg.sv ====
// Shared types, register indices and AES tables for the decryption core
// Modules import this package inside their bodies where they need it
`default_nettype none

package aes_pkg;

	typedef logic [31:0] aes_word_t;
	typedef aes_word_t [0:3] aes_block_t; // Word 0 is the most significant

	localparam int NUM_ROUNDS = 10;

	// Avalon register map
	localparam logic [3:0] REG_KEY0    = 4'd0;
	localparam logic [3:0] REG_MSG_EN0 = 4'd4;
	localparam logic [3:0] REG_MSG_DE0 = 4'd8;
	localparam logic [3:0] REG_START   = 4'd14;
	localparam logic [3:0] REG_DONE    = 4'd15;

	localparam logic [0:255][7:0] SBOX = {
		128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [0:255][7:0] INV_SBOX = {
		128'h52096ad53036a538bf40a39e81f3d7fb, 128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e, 128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692, 128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506, 128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673, 128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b, 128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f, 128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961, 128'h172b047eba77d626e169146355210c7d
	};

	localparam logic [0:9][7:0] RCON = 80'h01020408102040801b36;

	// S-box on all four bytes of a word
	function automatic aes_word_t sub_word(input aes_word_t w);
		return {SBOX[w[31:24]], SBOX[w[23:16]], SBOX[w[15:8]], SBOX[w[7:0]]};
	endfunction

	function automatic logic [7:0] inv_sub_byte(input logic [7:0] b);
		return INV_SBOX[b];
	endfunction

	// Multiply by x in GF(2^8)
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

endpackage

`default_nettype wire

// ==== src/aes_job_if.sv ====
// Decryption job between the register bank and the engine
// Four-phase req/ack, key and cipher held while req is high, plain while ack is high
`timescale 1ns/1ns
`default_nettype none

interface aes_job_if;
	import aes_pkg::*;

	logic       req;
	logic       ack;
	aes_block_t key;
	aes_block_t cipher;
	aes_block_t plain;

	modport bank (
		output req, key, cipher,
		input  ack, plain
	);

	modport engine (
		input  req, key, cipher,
		output ack, plain
	);

endinterface

`default_nettype wire

// ==== src/avalon_aes_interface.sv ====
// Avalon-MM register bank of the AES decryption core
// Key and ciphertext come in over the bus, plaintext goes back, start/done steer the job
// Reads are combinational, writes merge the enabled byte lanes
`timescale 1ns/1ns
`default_nettype none

module avalon_aes_interface (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              avl_read,
	input  wire logic              avl_write,
	input  wire logic              avl_cs,
	input  wire logic [3:0]        avl_byte_en,
	input  wire logic [3:0]        avl_addr,
	input  wire aes_pkg::aes_word_t avl_writedata,
	output aes_pkg::aes_word_t     avl_readdata,
	output aes_pkg::aes_word_t     export_data,
	aes_job_if.bank                job
);
	import aes_pkg::*;

	aes_word_t key_reg [4];
	aes_word_t en_reg [4];
	aes_word_t de_reg [4];
	logic      start_bit;
	logic      done_bit;
	logic      ack_q;
	logic      wr_en;
	logic      start_wr;  // Start bit after the lane merge
	logic      ack_rise;

	function automatic aes_word_t merge_lanes(input aes_word_t old, input aes_word_t data,
			input logic [3:0] be);
		aes_word_t res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (be[i])
				res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction

	assign wr_en    = avl_write && avl_cs;
	assign start_wr = avl_byte_en[0] ? avl_writedata[0] : start_bit;
	assign ack_rise = job.ack && !ack_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++) begin
				key_reg[i] <= '0;
				en_reg[i]  <= '0;
				de_reg[i]  <= '0;
			end
			start_bit <= 1'b0;
			done_bit  <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			ack_q <= job.ack;
			if (wr_en && avl_addr[3:2] == REG_KEY0[3:2])
				key_reg[avl_addr[1:0]] <= merge_lanes(key_reg[avl_addr[1:0]], avl_writedata,
					avl_byte_en);
			if (wr_en && avl_addr[3:2] == REG_MSG_EN0[3:2])
				en_reg[avl_addr[1:0]] <= merge_lanes(en_reg[avl_addr[1:0]], avl_writedata,
					avl_byte_en);
			if (wr_en && avl_addr == REG_START) begin
				start_bit <= start_wr;
				if (!start_wr)
					done_bit <= 1'b0; // Software acknowledges the result
			end
			if (ack_rise) begin
				for (int i = 0; i < 4; i++)
					de_reg[i] <= job.plain[i];
				done_bit <= 1'b1;
			end
		end
	end

	// Job request
	assign job.req    = start_bit && !done_bit && !job.ack;
	assign job.key    = {key_reg[0], key_reg[1], key_reg[2], key_reg[3]};
	assign job.cipher = {en_reg[0], en_reg[1], en_reg[2], en_reg[3]};

	always_comb begin
		avl_readdata = '0;
		if (avl_read && avl_cs) begin
			if (avl_addr[3:2] == REG_KEY0[3:2])
				avl_readdata = key_reg[avl_addr[1:0]];
			else if (avl_addr[3:2] == REG_MSG_EN0[3:2])
				avl_readdata = en_reg[avl_addr[1:0]];
			else if (avl_addr[3:2] == REG_MSG_DE0[3:2])
				avl_readdata = de_reg[avl_addr[1:0]];
			else if (avl_addr == REG_START)
				avl_readdata = {31'b0, start_bit};
			else if (avl_addr == REG_DONE)
				avl_readdata = {31'b0, done_bit};
		end
	end

	assign export_data = {en_reg[0][31:16], en_reg[3][15:0]}; // LED conduit

endmodule

`default_nettype wire

// ==== src/aes_decrypt_ctrl.sv ====
// Engine sequencer for the iterative AES-128 decryption
// Load, 10 forward key steps, initial AddRoundKey, 10 inverse rounds, then ack
`timescale 1ns/1ns
`default_nettype none

module aes_decrypt_ctrl (
	input  wire logic                clk,
	input  wire logic                rst,
	aes_job_if.engine                job,
	output logic                     ks_load,
	output logic                     ks_fwd,
	output logic                     ks_back,
	output aes_pkg::aes_block_t      key,
	input  wire aes_pkg::aes_block_t round_key,
	output logic                     rd_load,
	output logic                     rd_first,
	output logic                     rd_last,
	output logic                     rd_step,
	output aes_pkg::aes_block_t      cipher,
	input  wire aes_pkg::aes_block_t state
);
	import aes_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_EXPAND,
		ST_ADD_KEY,
		ST_ROUNDS,
		ST_HOLD_ACK
	} ctrl_state_t;

	ctrl_state_t st;
	logic [3:0]  rnd_cnt;
	logic        cnt_last;

	assign cnt_last = (rnd_cnt == 4'(NUM_ROUNDS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			st      <= ST_IDLE;
			rnd_cnt <= '0;
		end else begin
			case (st)
				ST_IDLE: if (job.req) begin
					st      <= ST_EXPAND;
					rnd_cnt <= '0;
				end
				ST_EXPAND: begin
					rnd_cnt <= cnt_last ? 4'd0 : rnd_cnt + 4'd1;
					if (cnt_last)
						st <= ST_ADD_KEY;
				end
				ST_ADD_KEY: st <= ST_ROUNDS;
				ST_ROUNDS: begin
					rnd_cnt <= rnd_cnt + 4'd1;
					if (cnt_last)
						st <= ST_HOLD_ACK; // Plain valid from here
				end
				ST_HOLD_ACK: if (!job.req)
					st <= ST_IDLE;
				default: st <= ST_IDLE;
			endcase
		end
	end

	// Datapath strobes
	assign ks_load  = (st == ST_IDLE) && job.req;
	assign rd_load  = ks_load;
	assign ks_fwd   = (st == ST_EXPAND);
	assign ks_back  = (st == ST_ADD_KEY) || ((st == ST_ROUNDS) && !cnt_last);
	assign rd_first = (st == ST_ADD_KEY);
	assign rd_step  = (st == ST_ROUNDS);
	assign rd_last  = cnt_last;

	assign key       = job.key;
	assign cipher    = job.cipher;
	assign job.plain = state;
	assign job.ack   = (st == ST_HOLD_ACK);

endmodule

`default_nettype wire

// ==== src/aes_key_schedule.sv ====
// AES-128 round keys computed on the fly
// load takes the cipher key, fwd steps to the next round key, back to the previous one
`timescale 1ns/1ns
`default_nettype none

module aes_key_schedule (
	input  wire logic                clk,
	input  wire aes_pkg::aes_block_t key,
	input  wire logic                load,
	input  wire logic                fwd,
	input  wire logic                back,
	output aes_pkg::aes_block_t      round_key
);
	import aes_pkg::*;

	logic [3:0] rc_idx; // Round constant of the next forward step
	logic [3:0] rc_sel;
	logic [7:0] rcon;
	aes_block_t next_key;
	aes_block_t prev_key;

	always_comb begin
		rc_sel = fwd ? rc_idx : rc_idx - 4'd1;
		rcon   = (rc_sel < 4'(NUM_ROUNDS)) ? RCON[rc_sel] : 8'h00;

		next_key[0] = round_key[0] ^ {rcon, 24'h0}
			^ sub_word({round_key[3][23:0], round_key[3][31:24]});
		next_key[1] = round_key[1] ^ next_key[0];
		next_key[2] = round_key[2] ^ next_key[1];
		next_key[3] = round_key[3] ^ next_key[2];

		// Words 1 to 3 fall out of neighbour XORs, word 0 needs the old word 3
		prev_key[3] = round_key[3] ^ round_key[2];
		prev_key[2] = round_key[2] ^ round_key[1];
		prev_key[1] = round_key[1] ^ round_key[0];
		prev_key[0] = round_key[0] ^ {rcon, 24'h0}
			^ sub_word({prev_key[3][23:0], prev_key[3][31:24]});
	end

	always_ff @(posedge clk) begin
		if (load) begin
			round_key <= key;
			rc_idx    <= '0;
		end else if (fwd) begin
			round_key <= next_key;
			rc_idx    <= rc_idx + 4'd1;
		end else if (back) begin
			round_key <= prev_key;
			rc_idx    <= rc_idx - 4'd1;
		end
	end

endmodule

`default_nettype wire

// ==== src/aes_inv_round.sv ====
// Cipher state register and one inverse AES round per clock
// first adds the round key alone, step runs a full round (no InvMixColumns when last)
`timescale 1ns/1ns
`default_nettype none

module aes_inv_round (
	input  wire logic                clk,
	input  wire aes_pkg::aes_block_t cipher,
	input  wire aes_pkg::aes_block_t round_key,
	input  wire logic                load,
	input  wire logic                first,
	input  wire logic                last,
	input  wire logic                step,
	output aes_pkg::aes_block_t      state
);
	import aes_pkg::*;

	aes_block_t sub_shift;
	aes_block_t added;
	aes_block_t mixed;

	// One column of InvMixColumns
	function automatic aes_word_t inv_mix_col(input aes_word_t col);
		logic [7:0] a [4];
		logic [7:0] x2 [4];
		logic [7:0] x4 [4];
		logic [7:0] x8 [4];
		aes_word_t  res;
		for (int i = 0; i < 4; i++) begin
			a[i]  = col[31-8*i -: 8];
			x2[i] = xtime(a[i]);
			x4[i] = xtime(x2[i]);
			x8[i] = xtime(x4[i]);
		end
		for (int r = 0; r < 4; r++) begin
			res[31-8*r -: 8] = (x8[r] ^ x4[r] ^ x2[r])          // 0e
				^ (x8[(r+1)%4] ^ x2[(r+1)%4] ^ a[(r+1)%4])     // 0b
				^ (x8[(r+2)%4] ^ x4[(r+2)%4] ^ a[(r+2)%4])     // 0d
				^ (x8[(r+3)%4] ^ a[(r+3)%4]);                  // 09
		end
		return res;
	endfunction

	always_comb begin
		// Row r rotates right by r columns
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				sub_shift[c][31-8*r -: 8] = inv_sub_byte(state[(c+4-r)%4][31-8*r -: 8]);
			end
		end
		added = sub_shift ^ round_key;
		for (int c = 0; c < 4; c++)
			mixed[c] = inv_mix_col(added[c]);
	end

	always_ff @(posedge clk) begin
		if (load)
			state <= cipher;
		else if (first)
			state <= state ^ round_key;
		else if (step)
			state <= last ? added : mixed;
	end

endmodule

`default_nettype wire

// ==== src/aes_top.sv ====
// Top of the AES-128 decryption peripheral
// Plain Avalon-MM slave ports and the LED conduit, register bank plus engine inside
`timescale 1ns/1ns
`default_nettype none

module aes_top (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               avl_read,
	input  wire logic               avl_write,
	input  wire logic               avl_cs,
	input  wire logic [3:0]         avl_byte_en,
	input  wire logic [3:0]         avl_addr,
	input  wire aes_pkg::aes_word_t avl_writedata,
	output aes_pkg::aes_word_t      avl_readdata,
	output aes_pkg::aes_word_t      export_data
);
	import aes_pkg::*;

	aes_block_t ks_key;
	aes_block_t round_key;
	aes_block_t rd_cipher;
	aes_block_t state;
	logic       ks_load;
	logic       ks_fwd;
	logic       ks_back;
	logic       rd_load;
	logic       rd_first;
	logic       rd_last;
	logic       rd_step;

	aes_job_if job ();

	avalon_aes_interface bank0 (
		.clk, .rst, .avl_read, .avl_write, .avl_cs, .avl_byte_en, .avl_addr,
		.avl_writedata, .avl_readdata, .export_data,
		.job (job.bank)
	);

	aes_decrypt_ctrl ctrl0 (
		.clk, .rst,
		.job       (job.engine),
		.ks_load, .ks_fwd, .ks_back,
		.key       (ks_key),
		.round_key,
		.rd_load, .rd_first, .rd_last, .rd_step,
		.cipher    (rd_cipher),
		.state
	);

	aes_key_schedule ks0 (
		.clk, .key(ks_key), .load(ks_load), .fwd(ks_fwd), .back(ks_back), .round_key
	);

	aes_inv_round rd0 (
		.clk, .cipher(rd_cipher), .round_key, .load(rd_load), .first(rd_first),
		.last(rd_last), .step(rd_step), .state
	);

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
// Clock and reset for the AES testbench
// 4 ns clock, reset held for 8 cycles and released on a falling edge
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);
	initial clk = 1'b0;
	always #2 clk = ~clk;

	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verification/aes_tb_sva.sv ====
// Handshake checks for the AES decryption core
// Bound into aes_top; the testbench reads fail_count at the end of the run
`timescale 1ns/1ns
`default_nettype none

module aes_tb_sva (
	input wire logic                clk,
	input wire logic                rst,
	input wire logic                req,
	input wire logic                ack,
	input wire aes_pkg::aes_block_t key,
	input wire aes_pkg::aes_block_t cipher
);
	int unsigned fail_count = 0;

	assert property (@(posedge clk) disable iff (rst) $fell(req) |-> ack)
	else begin
		fail_count++;
		$error("req dropped before ack was raised");
	end

	assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
	else begin
		fail_count++;
		$error("ack rose without a pending req");
	end

	assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
	else begin
		fail_count++;
		$error("ack dropped while req was still high");
	end

	// Job data frozen for the whole request
	assert property (@(posedge clk) disable iff (rst)
			req && $past(req) |-> $stable(key) && $stable(cipher))
	else begin
		fail_count++;
		$error("key or cipher changed while req was high");
	end

	assert property (@(posedge clk) disable iff (rst) $rose(req) |-> ##22 $rose(ack))
	else begin
		fail_count++;
		$error("ack did not rise 22 cycles after req");
	end

endmodule

bind aes_top aes_tb_sva sva0 (
	.clk, .rst, .req(job.req), .ack(job.ack), .key(job.key), .cipher(job.cipher)
);

`default_nettype wire

// ==== verification/aes_tb.sv ====
// Testbench for the AES-128 decryption peripheral
// Drives the Avalon slave of aes_top on falling edges and checks register and FIPS-197 results
`timescale 1ns/1ns
`default_nettype none

module aes_tb;
	import aes_pkg::*;

	logic       clk;
	logic       rst;
	logic       avl_read;
	logic       avl_write;
	logic       avl_cs;
	logic [3:0] avl_byte_en;
	logic [3:0] avl_addr;
	aes_word_t  avl_readdata;
	aes_word_t  avl_writedata;
	aes_word_t  export_data;
	logic [31:0] rng_state;
	int         checks;
	int         errors;
	int         err_mark;
	aes_word_t  key_model [4];
	aes_word_t  ct_model [4];

	tb_clock clk0 (.clk, .rst);

	aes_top dut0 (
		.clk, .rst, .avl_read, .avl_write, .avl_cs, .avl_byte_en, .avl_addr,
		.avl_writedata, .avl_readdata, .export_data
	);

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	// Old value keeps every lane whose enable is clear
	function automatic aes_word_t apply_byte_enables(aes_word_t old, aes_word_t data,
			logic [3:0] be);
		aes_word_t mask;
		mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		return (old & ~mask) | (data & mask);
	endfunction

	task automatic bus_write(input logic [3:0] addr, input aes_word_t data,
			input logic [3:0] be);
		@(negedge clk);
		avl_write     = 1'b1;
		avl_cs        = 1'b1;
		avl_addr      = addr;
		avl_writedata = data;
		avl_byte_en   = be;
		@(negedge clk);
		avl_write   = 1'b0;
		avl_cs      = 1'b0;
		avl_byte_en = 4'h0;
	endtask

	task automatic bus_read(input logic [3:0] addr, output aes_word_t data);
		@(negedge clk);
		avl_read = 1'b1;
		avl_cs   = 1'b1;
		avl_addr = addr;
		#1 data = avl_readdata; // Zero-latency read
		@(negedge clk);
		avl_read = 1'b0;
		avl_cs   = 1'b0;
	endtask

	task automatic check_value(input string name, input aes_word_t exp, input aes_word_t got);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_read(input logic [3:0] addr, input aes_word_t exp);
		aes_word_t rd;
		bus_read(addr, rd);
		check_value($sformatf("readdata[%0d]", addr), exp, rd);
	endtask

	task automatic report_test(input int num, input string name);
		$display("Test %0d %s finished with %0d errors", num, name, errors - err_mark);
		err_mark = errors;
	endtask

	task automatic wait_reset_release();
		for (int n = 0; n < 20 && rst; n++)
			@(negedge clk);
		checks++;
		assert (!rst)
		else begin
			errors++;
			$display("Timeout: reset was not released within 20 cycles");
		end
	endtask

	task automatic wait_done();
		aes_word_t rd;
		logic      seen;
		seen = 1'b0;
		for (int n = 0; n < 40 && !seen; n++) begin
			bus_read(REG_DONE, rd);
			seen = rd[0];
		end
		checks++;
		assert (seen)
		else begin
			errors++;
			$display("Timeout: done bit did not read 1 within 40 polls");
		end
	endtask

	task automatic run_decrypt(input aes_block_t key, input aes_block_t ct,
			input aes_block_t exp_plain);
		for (int i = 0; i < 4; i++) begin
			bus_write(REG_KEY0 + 4'(i), key[i], 4'hf);
			bus_write(REG_MSG_EN0 + 4'(i), ct[i], 4'hf);
			key_model[i] = key[i];
			ct_model[i]  = ct[i];
		end
		bus_write(REG_START, 32'h1, 4'hf);
		wait_done();
		for (int i = 0; i < 4; i++)
			check_read(REG_MSG_DE0 + 4'(i), exp_plain[i]);
	endtask

	initial begin
		aes_word_t rnd;
		aes_word_t data;
		int        sva_fails;
		avl_read      = 1'b0;
		avl_write     = 1'b0;
		avl_cs        = 1'b0;
		avl_byte_en   = 4'h0;
		avl_addr      = 4'h0;
		avl_writedata = '0;
		rng_state     = 32'd49447;
		checks        = 0;
		errors        = 0;
		err_mark      = 0;
		for (int i = 0; i < 4; i++) begin
			key_model[i] = '0; // Registers come out of reset as zero
			ct_model[i]  = '0;
		end
		wait_reset_release();

		for (int a = 0; a < 16; a++)
			check_read(4'(a), 32'h0);
		report_test(1, "reset state");

		for (int pass = 0; pass < 3; pass++) begin
			for (int i = 0; i < 8; i++) begin
				data = lcg_next();
				rnd  = lcg_next();
				bus_write(4'(i), data, rnd[27:24]);
				if (i < 4)
					key_model[i] = apply_byte_enables(key_model[i], data, rnd[27:24]);
				else
					ct_model[i-4] = apply_byte_enables(ct_model[i-4], data, rnd[27:24]);
			end
			for (int i = 0; i < 4; i++) begin
				check_read(REG_KEY0 + 4'(i), key_model[i]);
				check_read(REG_MSG_EN0 + 4'(i), ct_model[i]);
			end
		end
		// Plaintext, spare and done registers are read-only
		for (int a = 8; a < 16; a++) begin
			if (a != 14)
				bus_write(4'(a), lcg_next(), 4'hf);
		end
		for (int a = 8; a < 16; a++)
			check_read(4'(a), 32'h0);
		report_test(2, "byte-lane writes");

		@(negedge clk);
		check_value("export_data", {ct_model[0][31:16], ct_model[3][15:0]}, export_data);
		data = lcg_next();
		bus_write(REG_MSG_EN0, data, 4'hc);
		ct_model[0] = apply_byte_enables(ct_model[0], data, 4'hc);
		data = lcg_next();
		bus_write(REG_MSG_EN0 + 4'd3, data, 4'h3);
		ct_model[3] = apply_byte_enables(ct_model[3], data, 4'h3);
		check_value("export_data", {ct_model[0][31:16], ct_model[3][15:0]}, export_data);
		report_test(3, "export conduit");

		run_decrypt(128'h000102030405060708090a0b0c0d0e0f,
			128'h69c4e0d86a7b0430d8cdb78070b4c55a, 128'h00112233445566778899aabbccddeeff);
		report_test(4, "FIPS-197 C.1 decryption");

		bus_write(REG_START, 32'h0, 4'hf); // Clears done
		check_read(REG_DONE, 32'h0);
		run_decrypt(128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'h3925841d02dc09fbdc118597196a0b32, 128'h3243f6a8885a308d313198a2e0370734);
		bus_write(REG_START, 32'h0, 4'hf);
		check_read(REG_DONE, 32'h0);
		report_test(5, "FIPS-197 B decryption and done clearing");

		repeat (4) @(negedge clk);
		sva_fails = int'(dut0.sva0.fail_count);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			sva_fails);
		if (errors == 0 && sva_fails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
src/aes_pkg.sv
src/aes_job_if.sv
src/avalon_aes_interface.sv
src/aes_decrypt_ctrl.sv
src/aes_key_schedule.sv
src/aes_inv_round.sv
src/aes_top.sv
verification/tb_clock.sv
verification/aes_tb_sva.sv
verification/aes_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the AES decryption testbench with Verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module aes_tb -f compile.f -o aes_sim

# Let assertion errors accumulate so the testbench can report them at the end
./obj_dir/aes_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
	echo "run_sim: PASS"
else
	echo "run_sim: FAIL"
	exit 1
fi
